// ==== shell_macros.svh ====
`ifndef SHELL_MACROS_SVH
`define SHELL_MACROS_SVH

////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////

`define HOST_ADDR_W 3   // host word address
`define DATA_W      32  // host and memory data
`define MEM_ADDR_W  32  // memory byte address
`define PENDING_W   8   // outstanding write counter
`define COUNT_W     16  // fill word count

////////////////////////////////////////////////////////////
// timing
////////////////////////////////////////////////////////////

// cycles the engine is held in reset after a start
`define RESET_DELAY 8

`endif

// ==== shell_pkg.sv ====
`default_nettype none

`include "shell_macros.svh"

package shell_pkg;

    // host register map, word addresses
    typedef enum logic [`HOST_ADDR_W-1:0] {
        reg_ctrl      = 0,  // bit0 start, bit1 soft reset, bit2 irq enable
        reg_status    = 1,  // bit0 done, bit1 idle, bit2 irq pending
        reg_mem_base  = 2,
        reg_cfg_op    = 4,
        reg_cfg_dst   = 5,
        reg_cfg_count = 6,
        reg_cfg_value = 7
    } host_reg_e;

    // run sequencer states
    typedef enum logic [1:0] {
        st_idle       = 2'd0,
        st_reset_wait = 2'd1,
        st_busy_wait  = 2'd2,
        st_running    = 2'd3
    } run_state_e;

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // fill opcodes; unknown codes behave as op_fill_const
    typedef enum logic [1:0] {
        op_fill_const = 2'd0,  // every word gets value
        op_fill_incr  = 2'd1   // word gets value + index
    } fill_op_e;

endpackage

`default_nettype wire

// ==== host_regs.sv ====
`default_nettype none

`include "shell_macros.svh"

module host_regs
    import shell_pkg::*;
(
    input  wire                      ap_clk,
    input  wire                      reset,

    input  wire                      host_wr,
    input  wire                      host_rd,
    input  wire [`HOST_ADDR_W-1:0]   host_addr,
    input  wire [`DATA_W-1:0]        host_wdata,
    output logic [`DATA_W-1:0]       host_rdata,
    output logic                     host_rvalid,
    output logic                     interrupt,

    output logic                     run_start,
    output logic                     soft_reset,
    output logic [`MEM_ADDR_W-1:0]   mem_base,

    output logic                     cfg_wr,
    output host_reg_e                cfg_addr,
    output logic [`DATA_W-1:0]       cfg_data,

    input  wire run_state_e          run_state,
    input  wire                      run_done
);

    logic      regs_reset;
    host_reg_e host_reg;
    logic      irq_enable;
    logic      done;
    logic      irq_pending;
    logic      idle;

    assign regs_reset = reset | soft_reset;
    assign host_reg   = host_reg_e'(host_addr);
    assign idle       = (run_state == st_idle);

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////

    assign run_start  = host_wr && (host_reg == reg_ctrl) && host_wdata[0];
    assign soft_reset = host_wr && (host_reg == reg_ctrl) && host_wdata[1];

    // engine config goes straight through, engine registers it
    assign cfg_wr   = host_wr && (host_reg inside {reg_cfg_op, reg_cfg_dst,
                                                   reg_cfg_count, reg_cfg_value});
    assign cfg_addr = host_reg;
    assign cfg_data = host_wdata;

    always_ff @(posedge ap_clk) begin
        if (regs_reset) begin
            irq_enable <= 1'b0;
            mem_base   <= '0;
        end else if (host_wr) begin
            case (host_reg)
                reg_ctrl:     irq_enable <= host_wdata[2];
                reg_mem_base: mem_base   <= `MEM_ADDR_W'(host_wdata);
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // completion and interrupt
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ap_clk) begin
        if (regs_reset) begin
            done        <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            if (run_done) begin
                done <= 1'b1;
            end else if (run_start && idle) begin
                done <= 1'b0;  // only an accepted start clears it
            end

            if (run_done && irq_enable) begin
                irq_pending <= 1'b1;
            end else if (host_wr && (host_reg == reg_status) && host_wdata[2]) begin
                irq_pending <= 1'b0;  // write one to clear
            end
        end
    end

    assign interrupt = irq_pending;

    ////////////////////////////////////////////////////////////
    // read path, one cycle latency
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ap_clk) begin
        if (regs_reset) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= host_rd;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (host_rd) begin
            case (host_reg)
                reg_ctrl:     host_rdata <= `DATA_W'({irq_enable, 2'b00});
                reg_status:   host_rdata <= `DATA_W'({irq_pending, idle, done});
                reg_mem_base: host_rdata <= `DATA_W'(mem_base);
                default:      host_rdata <= '0;  // cfg regs are write only
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run_sequencer.sv ====
`default_nettype none

`include "shell_macros.svh"

module run_sequencer
    import shell_pkg::*;
(
    input  wire         ap_clk,
    input  wire         reset,

    input  wire         run_start,
    input  wire         busy,
    input  wire         pending_zero,

    output logic        engine_reset,
    output run_state_e  run_state,
    output logic        run_done
);

    localparam int CTR_W = $clog2(`RESET_DELAY + 1);

    logic [CTR_W-1:0] reset_ctr;
    logic             complete;

    // run is over once the engine is quiet and memory has acked everything
    assign complete = (run_state == st_running) && !busy && pending_zero;
    assign run_done = complete;

    // engine only leaves reset once the delay has elapsed
    assign engine_reset = !((run_state == st_busy_wait) || (run_state == st_running));

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            run_state <= st_idle;
            reset_ctr <= '0;
        end else begin
            case (run_state)
                st_idle: begin
                    reset_ctr <= '0;
                    if (run_start) begin
                        run_state <= st_reset_wait;
                    end
                end
                st_reset_wait: begin
                    if (reset_ctr == CTR_W'(`RESET_DELAY - 1)) begin
                        run_state <= st_busy_wait;
                        reset_ctr <= '0;
                    end else begin
                        reset_ctr <= reset_ctr + 1'b1;
                    end
                end
                st_busy_wait: begin
                    if (busy) begin  // wait for the engine to pick up
                        run_state <= st_running;
                    end
                end
                st_running: begin
                    if (complete) begin
                        run_state <= st_idle;
                    end
                end
                default: run_state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== fill_engine.sv ====
`default_nettype none

`include "shell_macros.svh"

module fill_engine
    import shell_pkg::*;
    import mem_pkg::*;
(
    input  wire                      ap_clk,
    input  wire                      engine_reset,

    input  wire                      cfg_wr,
    input  wire host_reg_e           cfg_addr,
    input  wire [`DATA_W-1:0]        cfg_data,

    output logic                     busy,
    output logic                     eng_wr_valid,
    output logic [`MEM_ADDR_W-1:0]   eng_wr_addr,
    output logic [`DATA_W-1:0]       eng_wr_data
);

    fill_op_e                cfg_op;
    logic [`MEM_ADDR_W-1:0]  cfg_dst;
    logic [`COUNT_W-1:0]     cfg_count;
    logic [`DATA_W-1:0]      cfg_value;

    logic                    launched;
    logic [`COUNT_W-1:0]     word_idx;

    ////////////////////////////////////////////////////////////
    // config registers, kept across engine reset
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ap_clk) begin
        if (cfg_wr) begin
            case (cfg_addr)
                reg_cfg_op:    cfg_op    <= fill_op_e'(cfg_data[1:0]);
                reg_cfg_dst:   cfg_dst   <= `MEM_ADDR_W'(cfg_data);
                reg_cfg_count: cfg_count <= `COUNT_W'(cfg_data);
                reg_cfg_value: cfg_value <= cfg_data;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // write generator
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ap_clk) begin
        if (engine_reset) begin
            launched     <= 1'b0;
            busy         <= 1'b0;
            eng_wr_valid <= 1'b0;
            word_idx     <= '0;
        end else if (!launched) begin
            launched <= 1'b1;  // busy goes up even for a zero count
            busy     <= 1'b1;
        end else if (busy) begin
            if (word_idx != cfg_count) begin
                eng_wr_valid <= 1'b1;
                word_idx     <= word_idx + 1'b1;
            end else begin
                eng_wr_valid <= 1'b0;
                busy         <= 1'b0;  // drops the cycle after the last write
            end
        end
    end

    // payload follows the index, qualified by eng_wr_valid
    always_ff @(posedge ap_clk) begin
        eng_wr_addr <= cfg_dst + (`MEM_ADDR_W'(word_idx) << 2);
        case (cfg_op)
            op_fill_incr: eng_wr_data <= cfg_value + `DATA_W'(word_idx);
            default:      eng_wr_data <= cfg_value;
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_write_port.sv ====
`default_nettype none

`include "shell_macros.svh"

module mem_write_port (
    input  wire                      ap_clk,
    input  wire                      reset,

    input  wire [`MEM_ADDR_W-1:0]    mem_base,
    input  wire                      eng_wr_valid,
    input  wire [`MEM_ADDR_W-1:0]    eng_wr_addr,
    input  wire [`DATA_W-1:0]        eng_wr_data,
    input  wire                      mem_ack,

    output logic                     mem_wr_valid,
    output logic [`MEM_ADDR_W-1:0]   mem_wr_addr,
    output logic [`DATA_W-1:0]       mem_wr_data,
    output logic                     pending_zero
);

    logic [`PENDING_W-1:0] pending;

    // no added latency on the write path
    assign mem_wr_valid = eng_wr_valid;
    assign mem_wr_addr  = eng_wr_addr + mem_base;
    assign mem_wr_data  = eng_wr_data;

    ////////////////////////////////////////////////////////////
    // outstanding write count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            case ({mem_wr_valid, mem_ack})
                2'b10: pending <= pending + 1'b1;
                2'b01: begin
                    // acks from before a soft reset must not wrap the count
                    if (pending != '0) begin
                        pending <= pending - 1'b1;
                    end
                end
                default: ;  // both or neither, count holds
            endcase
        end
    end

    assign pending_zero = (pending == '0);

endmodule

`default_nettype wire

// ==== accel_shell.sv ====
`default_nettype none

`include "shell_macros.svh"

module accel_shell
    import shell_pkg::*;
(
    input  wire                      ap_clk,
    input  wire                      reset,

    // host register port
    input  wire                      host_wr,
    input  wire                      host_rd,
    input  wire [`HOST_ADDR_W-1:0]   host_addr,
    input  wire [`DATA_W-1:0]        host_wdata,
    output wire [`DATA_W-1:0]        host_rdata,
    output wire                      host_rvalid,
    output wire                      interrupt,

    // memory write port
    output wire                      mem_wr_valid,
    output wire [`MEM_ADDR_W-1:0]    mem_wr_addr,
    output wire [`DATA_W-1:0]        mem_wr_data,
    input  wire                      mem_ack
);

    wire                      run_start;
    wire                      soft_reset;
    wire                      core_reset;
    wire [`MEM_ADDR_W-1:0]    mem_base;

    wire                      cfg_wr;
    wire host_reg_e           cfg_addr;
    wire [`DATA_W-1:0]        cfg_data;

    wire run_state_e          run_state;
    wire                      run_done;
    wire                      engine_reset;
    wire                      pending_zero;

    wire                      busy;
    wire                      eng_wr_valid;
    wire [`MEM_ADDR_W-1:0]    eng_wr_addr;
    wire [`DATA_W-1:0]        eng_wr_data;

    assign core_reset = reset | soft_reset;

    host_regs host_regs (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .host_wr      (host_wr),
        .host_rd      (host_rd),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_rdata   (host_rdata),
        .host_rvalid  (host_rvalid),
        .interrupt    (interrupt),
        .run_start    (run_start),
        .soft_reset   (soft_reset),
        .mem_base     (mem_base),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .run_state    (run_state),
        .run_done     (run_done)
    );

    run_sequencer run_sequencer (
        .ap_clk       (ap_clk),
        .reset        (core_reset),
        .run_start    (run_start),
        .busy         (busy),
        .pending_zero (pending_zero),
        .engine_reset (engine_reset),
        .run_state    (run_state),
        .run_done     (run_done)
    );

    fill_engine fill_engine (
        .ap_clk       (ap_clk),
        .engine_reset (engine_reset | soft_reset),  // soft reset stops writes at once
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .busy         (busy),
        .eng_wr_valid (eng_wr_valid),
        .eng_wr_addr  (eng_wr_addr),
        .eng_wr_data  (eng_wr_data)
    );

    mem_write_port mem_write_port (
        .ap_clk       (ap_clk),
        .reset        (core_reset),
        .mem_base     (mem_base),
        .eng_wr_valid (eng_wr_valid),
        .eng_wr_addr  (eng_wr_addr),
        .eng_wr_data  (eng_wr_data),
        .mem_ack      (mem_ack),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .pending_zero (pending_zero)
    );

endmodule

`default_nettype wire

// ==== shell_checker.sv ====
`default_nettype none

`include "shell_macros.svh"

module shell_checker
    import mem_pkg::*;
(
    input wire                    ap_clk,
    input wire                    mem_wr_valid,
    input wire [`MEM_ADDR_W-1:0]  mem_wr_addr,
    input wire [`DATA_W-1:0]      mem_wr_data,
    input wire                    mem_ack,
    input wire                    interrupt,
    input wire                    host_rvalid,
    input wire [`DATA_W-1:0]      host_rdata
);

    int error_count  = 0;
    int writes_seen  = 0;
    int status_reads = 0;
    int write_idx    = 0;   // writes seen in the current run
    int outstanding  = 0;   // writes memory has not acked yet

    fill_op_e               exp_op    = op_fill_const;
    logic [`MEM_ADDR_W-1:0] exp_dst   = '0;
    logic [`MEM_ADDR_W-1:0] exp_base  = '0;
    logic [`DATA_W-1:0]     exp_value = '0;
    int                     exp_count = 0;  // nothing may be written before the first run

    bit         status_armed = 1'b0;
    bit         status_exact = 1'b0;
    logic [2:0] exp_status   = '0;  // irq pending, idle, done

    ////////////////////////////////////////////////////////////
    // hooks for the testbench
    ////////////////////////////////////////////////////////////

    task automatic load_entry(input logic [1:0] op, input logic [`MEM_ADDR_W-1:0] dst,
                              input int count, input logic [`DATA_W-1:0] value,
                              input logic [`MEM_ADDR_W-1:0] base);
        exp_op    = fill_op_e'(op);
        exp_dst   = dst;
        exp_count = count;
        exp_value = value;
        exp_base  = base;
        write_idx = 0;
    endtask

    // after a soft reset no further write may appear
    task automatic freeze_writes();
        exp_count = write_idx;
    endtask

    task automatic arm_status(input bit exact, input logic [2:0] expected);
        status_armed = 1'b1;
        status_exact = exact;
        exp_status   = expected;
    endtask

    task automatic note_failure(input string msg);
        $display("%0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_write_count();
        compare_value("write_count", exp_count, write_idx);
    endtask

    task automatic print_summary();
        $display("summary: %0d writes checked, %0d status reads checked, %0d errors",
                 writes_seen, status_reads, error_count);
    endtask

    ////////////////////////////////////////////////////////////
    // port monitor
    ////////////////////////////////////////////////////////////

    task automatic check_write();
        logic [`MEM_ADDR_W-1:0] exp_addr;
        logic [`DATA_W-1:0]     exp_data;
        if (write_idx >= exp_count) begin
            note_failure("memory write issued when none was expected");
        end else begin
            exp_addr = exp_base + exp_dst + `MEM_ADDR_W'(write_idx) * 4;
            if (exp_op == op_fill_incr) begin
                exp_data = exp_value + `DATA_W'(write_idx);
            end else begin
                exp_data = exp_value;  // any other code fills a constant
            end
            compare_value("mem_wr_addr", exp_addr, mem_wr_addr);
            compare_value("mem_wr_data", exp_data, mem_wr_data);
        end
        write_idx++;
        writes_seen++;
    endtask

    task automatic check_status();
        status_reads++;
        if (host_rdata[0] && outstanding != 0) begin
            note_failure("status shows done while memory writes are still unacknowledged");
        end
        if (status_exact) begin
            compare_value("host_rdata", 32'(exp_status), host_rdata);
            compare_value("interrupt", 32'(exp_status[2]), 32'(interrupt));
            compare_value("mem_wr_valid", 32'd0, 32'(mem_wr_valid));
        end
        status_armed = 1'b0;
    endtask

    always @(posedge ap_clk) begin
        if (mem_wr_valid) begin
            check_write();
        end
        if (mem_wr_valid && !mem_ack) begin
            outstanding++;
        end else if (!mem_wr_valid && mem_ack) begin
            outstanding--;
        end
        if (host_rvalid && status_armed) begin
            check_status();
        end
    end

endmodule

`default_nettype wire

// ==== tb_accel_shell.sv ====
`default_nettype none

`include "shell_macros.svh"

module tb_accel_shell
    import shell_pkg::*;
    import mem_pkg::*;
();

    localparam int MAX_ACK_DELAY = 6;

    typedef struct packed {
        logic [1:0]             op;
        logic [`MEM_ADDR_W-1:0] dst;
        logic [`COUNT_W-1:0]    count;
        logic [`DATA_W-1:0]     value;
        logic [`MEM_ADDR_W-1:0] base;
        logic                   irq_en;
        logic                   soft_rst;  // soft reset halfway through the run
    } run_entry_t;

    // op, dst, count, value, mem_base, irq enable, soft reset
    run_entry_t runs [7] = '{
        '{op_fill_const, 32'h0000_0100, 16'd5,  32'hcafe_0001, 32'h1000_0000, 1'b1, 1'b0},
        '{op_fill_incr,  32'h0000_0040, 16'd12, 32'h0000_0010, 32'h2000_0000, 1'b0, 1'b0},
        '{op_fill_const, 32'h0000_0200, 16'd0,  32'h1234_5678, 32'h3000_0000, 1'b1, 1'b0},
        '{op_fill_incr,  32'h0000_1000, 16'd20, 32'h0000_0100, 32'h4000_0000, 1'b1, 1'b1},
        '{op_fill_const, 32'h0000_0080, 16'd7,  32'hdead_beef, 32'h5000_0000, 1'b1, 1'b0},
        '{2'd3,          32'h0000_0300, 16'd4,  32'h0bad_f00d, 32'h6000_0000, 1'b0, 1'b0},
        '{op_fill_incr,  32'hffff_fff0, 16'd6,  32'hffff_fffe, 32'h0000_0008, 1'b1, 1'b0}
    };

    logic                     ap_clk;
    logic                     reset;
    logic                     host_wr;
    logic                     host_rd;
    logic [`HOST_ADDR_W-1:0]  host_addr;
    logic [`DATA_W-1:0]       host_wdata;
    logic                     mem_ack;
    wire  [`DATA_W-1:0]       host_rdata;
    wire                      host_rvalid;
    wire                      interrupt;
    wire                      mem_wr_valid;
    wire  [`MEM_ADDR_W-1:0]   mem_wr_addr;
    wire  [`DATA_W-1:0]       mem_wr_data;

    int ack_due[$];  // cycle each pending ack is due
    int clk_count = 0;
    int seed      = 50;

    accel_shell UUT (.*);

    shell_checker scoreboard (.*);

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    ////////////////////////////////////////////////////////////
    // memory model with one ack strobe per write
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(seed));
        forever begin
            @(posedge ap_clk);
            clk_count = clk_count + 1;
            if (mem_wr_valid) begin
                ack_due.push_back(clk_count + int'($urandom_range(MAX_ACK_DELAY, 1)));
            end
            if (ack_due.size() != 0 && ack_due[0] <= clk_count) begin
                mem_ack <= 1'b1;
                void'(ack_due.pop_front());
            end else begin
                mem_ack <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // host driver
    ////////////////////////////////////////////////////////////

    task automatic write_reg(input host_reg_e addr, input logic [`DATA_W-1:0] data);
        @(posedge ap_clk);
        host_wr    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge ap_clk);
        host_wr <= 1'b0;
    endtask

    // a read that is not exact only checks done against outstanding writes
    task automatic read_status(input bit exact, input logic [2:0] expected,
                               output logic [`DATA_W-1:0] data);
        int waited;
        @(posedge ap_clk);
        scoreboard.arm_status(exact, expected);
        host_rd   <= 1'b1;
        host_addr <= reg_status;
        @(posedge ap_clk);
        host_rd <= 1'b0;
        waited  = 0;
        data    = '0;
        do begin
            @(posedge ap_clk);
            waited++;
        end while (!host_rvalid && waited < 4);
        if (host_rvalid) begin
            data = host_rdata;
        end else begin
            scoreboard.note_failure("status read got no response");
        end
    endtask

    task automatic run_entry(input run_entry_t e);
        logic [`DATA_W-1:0] status;
        scoreboard.load_entry(e.op, e.dst, e.count, e.value, e.base);
        write_reg(reg_mem_base, e.base);
        write_reg(reg_cfg_op, `DATA_W'(e.op));
        write_reg(reg_cfg_dst, e.dst);
        write_reg(reg_cfg_count, `DATA_W'(e.count));
        write_reg(reg_cfg_value, e.value);
        write_reg(reg_ctrl, {29'd0, e.irq_en, 2'b01});  // start
        if (e.soft_rst) begin
            while (scoreboard.write_idx < e.count / 2) @(posedge ap_clk);
            write_reg(reg_ctrl, 32'h2);
            @(negedge ap_clk);
            scoreboard.freeze_writes();
            while (ack_due.size() != 0) @(posedge ap_clk);  // let stray acks drain
            read_status(1'b1, 3'b010, status);
        end else begin
            do begin
                read_status(1'b0, 3'b000, status);
            end while (!status[0]);
            scoreboard.check_write_count();
            read_status(1'b1, {e.irq_en, 2'b11}, status);
            if (e.irq_en) begin
                write_reg(reg_status, 32'h4);  // clear pending irq
                read_status(1'b1, 3'b011, status);
            end
        end
    endtask

    // each run needs its reset delay, words and ack latency plus host traffic
    function automatic int run_limit_cycles();
        int total;
        total = 200;
        foreach (runs[i]) begin
            total += `RESET_DELAY + int'(runs[i].count) + MAX_ACK_DELAY + 100;
        end
        return total;
    endfunction

    initial begin
        #(run_limit_cycles() * 10);
        $display("timeout: the tests did not finish within %0d cycles", run_limit_cycles());
        scoreboard.print_summary();
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [`DATA_W-1:0] status;
        reset      = 1'b1;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        mem_ack    = 1'b0;
        repeat (2) @(posedge ap_clk);
        reset <= 1'b0;
        read_status(1'b1, 3'b010, status);  // idle, not done, no irq
        foreach (runs[i]) begin
            run_entry(runs[i]);
        end
        scoreboard.print_summary();
        if (scoreboard.error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
shell_pkg.sv
mem_pkg.sv
host_regs.sv
run_sequencer.sv
fill_engine.sv
mem_write_port.sv
accel_shell.sv
shell_checker.sv
tb_accel_shell.sv

// ==== Bender.yml ====
package:
  name: accel_shell

sources:
  - include_dirs:
      - .
    files:
      - shell_pkg.sv
      - mem_pkg.sv
      - host_regs.sv
      - run_sequencer.sv
      - fill_engine.sv
      - mem_write_port.sv
      - accel_shell.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - shell_checker.sv
      - tb_accel_shell.sv
